// File: build.f
common/irq_pkg.sv
irq_ctrl/irq_sampler.sv
irq_ctrl/irq_group_sel.sv
irq_ctrl/irq_arbiter.sv
design/irq_ctrl_top.sv
verification/irq_checker.sv
verification/tb_irq_ctrl.sv

// File: Bender.yml
package:
  name: irq_ctrl

sources:
  - files:
      - common/irq_pkg.sv
      - irq_ctrl/irq_sampler.sv
      - irq_ctrl/irq_group_sel.sv
      - irq_ctrl/irq_arbiter.sv
      - design/irq_ctrl_top.sv
  - target: test
    files:
      - verification/irq_checker.sv
      - verification/tb_irq_ctrl.sv

// File: verification/tb_irq_ctrl.sv
////////////////////////////////////////////////////////////
// Interrupt controller testbench
// Clock, reset, stimulus table and handshake driver
////////////////////////////////////////////////////////////

module tb_irq_ctrl;

  localparam int FIXED_ROWS   = 10;
  localparam int RAND_ROWS    = 16;
  localparam int ROW_NUM      = FIXED_ROWS + RAND_ROWS;
  localparam int REQ_TIMEOUT  = 20;
  localparam int QUIET_CYCLES = 4;

  // One table row
  typedef struct packed {
    logic [31:0] mie;
    logic        glb;
    logic [31:0] irq;
    logic [3:0]  dly;
    logic [4:0]  id;
    logic        req;
  } row_t;

  logic             clk;
  logic             rst_n;
  logic [31:0]      irq;
  logic             mie_we;
  logic [31:0]      mie_wdata;
  logic             glb_en;
  logic             ack;
  logic [31:0]      mip;
  logic [31:0]      mie;
  logic             wu;
  logic             req;
  irq_pkg::irq_id_t id;
  row_t             rows [ROW_NUM];
  integer           seed;

  irq_ctrl_top dut0 (
    .clk_i        ( clk       ),
    .rst_n_i      ( rst_n     ),
    .irq_i        ( irq       ),
    .mie_we_i     ( mie_we    ),
    .mie_wdata_i  ( mie_wdata ),
    .irq_glb_en_i ( glb_en    ),
    .irq_ack_i    ( ack       ),
    .mip_o        ( mip       ),
    .mie_o        ( mie       ),
    .irq_wu_o     ( wu        ),
    .irq_req_o    ( req       ),
    .irq_id_o     ( id        )
  );

  irq_checker checker0 (
    .clk_i        ( clk       ),
    .rst_n_i      ( rst_n     ),
    .irq_i        ( irq       ),
    .mie_we_i     ( mie_we    ),
    .mie_wdata_i  ( mie_wdata ),
    .irq_glb_en_i ( glb_en    ),
    .irq_ack_i    ( ack       ),
    .mip_o        ( mip       ),
    .mie_o        ( mie       ),
    .irq_wu_o     ( wu        ),
    .irq_req_o    ( req       ),
    .irq_id_o     ( id        )
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // Inputs change just after the rising edge
  task automatic next_cycle();
    @(posedge clk);
    #1;
  endtask

  task automatic set_row(input int i, input logic [31:0] m, input logic g, input logic [31:0] l,
                         input logic [3:0] d, input logic [4:0] exp_id, input logic exp_req);
    rows[i].mie = m;
    rows[i].glb = g;
    rows[i].irq = l;
    rows[i].dly = d;
    rows[i].id  = exp_id;
    rows[i].req = exp_req;
  endtask

  task automatic load_table();
    logic [31:0] rnd_irq;
    logic [31:0] rnd_mie;
    logic [3:0]  rnd_dly;
    logic [5:0]  pick;
    //       mie           glb   irq           dly   id     req
    set_row(0, 32'hFFFF_FFFF, 1'b1, 32'h0000_0888, 4'd0, 5'd11, 1'b1);
    set_row(1, 32'hFFFF_FFFF, 1'b1, 32'h0000_0088, 4'd3, 5'd3,  1'b1);
    set_row(2, 32'hFFFF_FFFF, 1'b1, 32'h0001_0080, 4'd0, 5'd7,  1'b1);
    set_row(3, 32'hFFFF_FFFF, 1'b1, 32'h8001_0000, 4'd1, 5'd31, 1'b1);
    set_row(4, 32'h0000_0888, 1'b1, 32'hFFFF_0000, 4'd0, 5'd0,  1'b0);
    set_row(5, 32'hFFFF_0000, 1'b1, 32'h0104_0000, 4'd2, 5'd24, 1'b1);
    set_row(6, 32'hFFFF_FFFF, 1'b0, 32'h0000_0800, 4'd0, 5'd0,  1'b0);
    set_row(7, 32'h0000_0000, 1'b1, 32'hFFFF_FFFF, 4'd0, 5'd0,  1'b0);
    set_row(8, 32'h0000_0080, 1'b1, 32'h0000_0888, 4'd0, 5'd7,  1'b1);
    set_row(9, 32'hFFFF_FFFF, 1'b1, 32'h0000_7777, 4'd0, 5'd0,  1'b0);
    // Random rows graded by the checker's rule
    for (int i = FIXED_ROWS; i < ROW_NUM; i++) begin
      rnd_irq = $random(seed);
      rnd_mie = $random(seed);
      rnd_dly = $unsigned($random(seed)) % 4;
      pick    = checker0.rule_pick(rnd_irq, rnd_mie);
      set_row(i, rnd_mie, 1'b1, rnd_irq, rnd_dly, pick[4:0], pick[5]);
    end
  endtask

  // Ack after a delay while MEI is raised to tempt a new id
  task automatic run_handshake(input int n, input logic [3:0] dly);
    int cycles;
    next_cycle();
    if (dly > 0) begin
      irq = irq | 32'h0000_0800;
    end
    repeat (dly) next_cycle();
    ack    = 1'b1;
    cycles = 0;
    @(negedge clk);
    while (req && cycles < REQ_TIMEOUT) begin
      @(negedge clk);
      cycles++;
    end
    if (req) begin
      checker0.report_failure($sformatf("test %0d: request never dropped after ack", n));
    end
  endtask

  task automatic apply_row(input int n, input row_t r);
    int cycles;
    checker0.begin_test();
    // mie write with all lines quiet
    mie_we    = 1'b1;
    mie_wdata = r.mie;
    glb_en    = r.glb;
    irq       = '0;
    next_cycle();
    mie_we = 1'b0;
    irq    = r.irq;
    if (r.req) begin
      // Edges counted from the first one that samples the new lines
      cycles = 0;
      @(negedge clk);
      while (!req && cycles < REQ_TIMEOUT) begin
        @(negedge clk);
        cycles++;
      end
      if (!req) begin
        checker0.report_failure($sformatf("test %0d: no request within %0d cycles",
                                          n, REQ_TIMEOUT));
      end else begin
        checker0.check_delivery(r.id, cycles);
        run_handshake(n, r.dly);
      end
    end else begin
      repeat (QUIET_CYCLES) begin
        @(negedge clk);
        checker0.check_req(1'b0);
      end
    end
    // Release ack and lines together
    next_cycle();
    ack = 1'b0;
    irq = '0;
    repeat (3) next_cycle();
    checker0.end_test(n, $sformatf("mie 0x%h glb %0d irq 0x%h", r.mie, r.glb, r.irq));
  endtask

  initial begin
    seed      = 38;
    // Busy inputs during reset must not reach the outputs
    rst_n     = 1'b0;
    irq       = '1;
    mie_we    = 1'b1;
    mie_wdata = '1;
    glb_en    = 1'b1;
    ack       = 1'b0;
    load_table();
    checker0.begin_test();
    repeat (10) next_cycle();
    rst_n     = 1'b1;
    irq       = '0;
    mie_we    = 1'b0;
    mie_wdata = '0;
    glb_en    = 1'b0;
    repeat (3) begin
      @(negedge clk);
      checker0.check_req(1'b0);
    end
    next_cycle();
    checker0.end_test(0, "reset");
    for (int i = 0; i < ROW_NUM; i++) begin
      apply_row(i + 1, rows[i]);
    end
    $display("tests run: %0d, errors: %0d", checker0.test_count, checker0.err_count);
    if (checker0.err_count == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

// File: verification/irq_checker.sv
////////////////////////////////////////////////////////////
// Interrupt controller monitor
// Reference model of mip, mie and wake-up, handshake rules
// Priority rule, per-test reporting and error counts
////////////////////////////////////////////////////////////

module irq_checker (
  input logic                        clk_i,
  input logic                        rst_n_i,
  input logic [irq_pkg::IRQ_NUM-1:0] irq_i,
  input logic                        mie_we_i,
  input logic [irq_pkg::IRQ_NUM-1:0] mie_wdata_i,
  input logic                        irq_glb_en_i,
  input logic                        irq_ack_i,
  input logic [irq_pkg::IRQ_NUM-1:0] mip_o,
  input logic [irq_pkg::IRQ_NUM-1:0] mie_o,
  input logic                        irq_wu_o,
  input logic                        irq_req_o,
  input irq_pkg::irq_id_t            irq_id_o
);

  // Software 3, timer 7, external 11, custom 31 to 16
  localparam logic [31:0] IMPL_BITS = 32'hFFFF_0888;

  int               err_count = 0;
  int               test_count = 0;
  int               test_errs_start = 0;
  logic [31:0]      exp_mip = '0;
  logic [31:0]      exp_mie = '0;
  logic             rst_at_edge = 1'b0;
  logic             ack_at_edge = 1'b0;
  logic             glb_at_edge = 1'b0;
  logic             req_prev = 1'b0;
  irq_pkg::irq_id_t id_prev = '0;

  task automatic cmp_value(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      err_count++;
      $display("error %s: got 0x%0h expected 0x%0h at %0t", name, got, exp, $time);
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Reference model, inputs taken at the clock edge
  ////////////////////////////////////////////////////////////

  always @(posedge clk_i) begin
    rst_at_edge <= rst_n_i;
    ack_at_edge <= irq_ack_i;
    glb_at_edge <= irq_glb_en_i;
    if (!rst_n_i) begin
      exp_mip <= '0;
      exp_mie <= '0;
    end else begin
      exp_mip <= irq_i;
      // Only implemented enable bits stick
      if (mie_we_i) begin
        exp_mie <= mie_wdata_i & IMPL_BITS;
      end
    end
  end

  // Outputs compared mid-cycle, away from the edge
  always @(negedge clk_i) begin
    cmp_value("mip_o", mip_o, exp_mip);
    cmp_value("mie_o", mie_o, exp_mie);
    cmp_value("irq_wu_o", irq_wu_o, |(exp_mip & exp_mie));
    if (!rst_at_edge) begin
      cmp_value("irq_req_o", irq_req_o, 1'b0);
      cmp_value("irq_id_o", irq_id_o, '0);
    end else begin
      if (!req_prev && irq_req_o) begin
        // Rise needs ack low and global enable
        if (ack_at_edge || !glb_at_edge) begin
          cmp_value("irq_req_o", irq_req_o, 1'b0);
        end
      end else begin
        // Id moves only on a request rise
        cmp_value("irq_id_o", irq_id_o, id_prev);
      end
      // Held until ack, dropped right after it
      if (req_prev) begin
        cmp_value("irq_req_o", irq_req_o, !ack_at_edge);
      end
    end
    req_prev = irq_req_o;
    id_prev  = irq_id_o;
  end

  ////////////////////////////////////////////////////////////
  // Services for the stimulus side
  ////////////////////////////////////////////////////////////

  // Returns {valid, id}; external, software, timer, then top custom line
  function automatic logic [5:0] rule_pick(input logic [31:0] lines, input logic [31:0] en);
    logic [31:0] act;
    logic [5:0]  pick;
    act  = lines & en & IMPL_BITS;
    pick = '0;
    if (act[11]) begin
      pick = {1'b1, 5'd11};
    end else if (act[3]) begin
      pick = {1'b1, 5'd3};
    end else if (act[7]) begin
      pick = {1'b1, 5'd7};
    end else begin
      for (int i = 31; i >= 16; i--) begin
        if (act[i] && !pick[5]) begin
          pick = {1'b1, 5'(i)};
        end
      end
    end
    return pick;
  endfunction

  task automatic check_req(input logic exp);
    cmp_value("irq_req_o", irq_req_o, exp);
  endtask

  // Two edges from a line change to the request
  task automatic check_delivery(input irq_pkg::irq_id_t exp_id, input int latency);
    cmp_value("irq_id_o", irq_id_o, exp_id);
    cmp_value("irq_req_o latency", latency, 2);
  endtask

  task automatic report_failure(input string msg);
    err_count++;
    $display("%s", msg);
  endtask

  task automatic begin_test();
    test_errs_start = err_count;
  endtask

  task automatic end_test(input int n, input string desc);
    test_count++;
    if (err_count == test_errs_start) begin
      $display("test %0d %s: pass", n, desc);
    end else begin
      $display("test %0d %s: FAIL, %0d errors", n, desc, err_count - test_errs_start);
    end
  endtask

endmodule

// File: design/irq_ctrl_top.sv
////////////////////////////////////////////////////////////
// Machine-mode interrupt controller top level
// Sampler, group selector array and arbiter
////////////////////////////////////////////////////////////

module irq_ctrl_top (
  // Clock and reset
  input  logic                        clk_i,
  input  logic                        rst_n_i,

  // Interrupt lines and mie write port
  input  logic [irq_pkg::IRQ_NUM-1:0] irq_i,
  input  logic                        mie_we_i,
  input  logic [irq_pkg::IRQ_NUM-1:0] mie_wdata_i,

  // Global enable and core handshake
  input  logic                        irq_glb_en_i,
  input  logic                        irq_ack_i,

  // Status and delivery
  output logic [irq_pkg::IRQ_NUM-1:0] mip_o,
  output logic [irq_pkg::IRQ_NUM-1:0] mie_o,
  output logic                        irq_wu_o,
  output logic                        irq_req_o,
  output irq_pkg::irq_id_t            irq_id_o
);

  irq_pkg::irq_word_u                                 pend_en;
  logic [irq_pkg::GROUP_NUM-1:0]                      grp_valid;
  logic [irq_pkg::GROUP_NUM*irq_pkg::GROUP_IDX_W-1:0] grp_idx;

  irq_sampler sampler_i (
    .clk_i          ( clk_i        ),
    .rst_n_i        ( rst_n_i      ),
    .irq_i          ( irq_i        ),
    .mie_we_i       ( mie_we_i     ),
    .mie_wdata_i    ( mie_wdata_i  ),
    .mip_o          ( mip_o        ),
    .mie_o          ( mie_o        ),
    .irq_pend_en_o  ( pend_en      ),
    .irq_wu_o       ( irq_wu_o     )
  );

  // One selector per slice of eight lines
  for (genvar g = 0; g < irq_pkg::GROUP_NUM; g++) begin : gen_group
    irq_group_sel group_sel_i (
      .pend_i       ( pend_en.flat[g*irq_pkg::GROUP_SIZE +: irq_pkg::GROUP_SIZE]   ),
      .grp_valid_o  ( grp_valid[g]                                                 ),
      .grp_idx_o    ( grp_idx[g*irq_pkg::GROUP_IDX_W +: irq_pkg::GROUP_IDX_W]      )
    );
  end

  irq_arbiter arbiter_i (
    .clk_i          ( clk_i        ),
    .rst_n_i        ( rst_n_i      ),
    .irq_pend_en_i  ( pend_en      ),
    .grp_valid_i    ( grp_valid    ),
    .grp_idx_i      ( grp_idx      ),
    .irq_glb_en_i   ( irq_glb_en_i ),
    .irq_ack_i      ( irq_ack_i    ),
    .irq_req_o      ( irq_req_o    ),
    .irq_id_o       ( irq_id_o     )
  );

endmodule

// File: irq_ctrl/irq_arbiter.sv
////////////////////////////////////////////////////////////
// Fixed-priority interrupt choice across standard bits and groups
// Four-phase req/ack FSM with latched id
////////////////////////////////////////////////////////////

module irq_arbiter (
  // Clock and reset
  input  logic                                            clk_i,
  input  logic                                            rst_n_i,

  // Enabled pending word, field view used here
  input  irq_pkg::irq_word_u                              irq_pend_en_i,

  // Group selector results
  input  logic [irq_pkg::GROUP_NUM-1:0]                   grp_valid_i,
  input  logic [irq_pkg::GROUP_NUM*irq_pkg::GROUP_IDX_W-1:0] grp_idx_i,

  // mstatus.MIE
  input  logic                                            irq_glb_en_i,

  // Handshake with the core
  input  logic                                            irq_ack_i,
  output logic                                            irq_req_o,
  output irq_pkg::irq_id_t                                irq_id_o
);

  logic [1:0]       state_q;
  logic [1:0]       state_d;
  irq_pkg::irq_id_t id_q;
  irq_pkg::irq_id_t sel_id;
  logic             sel_valid;
  logic             launch;

  ////////////////////////////////////////////////////////////
  // Priority choice
  ////////////////////////////////////////////////////////////

  // External, then software, then timer, then top valid group
  always_comb begin
    sel_id    = '0;
    sel_valid = 1'b1;
    if (irq_pend_en_i.fields.meie) begin
      sel_id = irq_pkg::IRQ_MEI;
    end else if (irq_pend_en_i.fields.msie) begin
      sel_id = irq_pkg::IRQ_MSI;
    end else if (irq_pend_en_i.fields.mtie) begin
      sel_id = irq_pkg::IRQ_MTI;
    end else begin
      sel_valid = 1'b0;
      // Higher group number overrides lower
      for (int g = 0; g < irq_pkg::GROUP_NUM; g++) begin
        if (grp_valid_i[g]) begin
          sel_valid = 1'b1;
          sel_id    = {g[irq_pkg::GROUP_NUM_W-1:0],
                       grp_idx_i[g*irq_pkg::GROUP_IDX_W +: irq_pkg::GROUP_IDX_W]};
        end
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // Handshake FSM
  ////////////////////////////////////////////////////////////

  // New request only from idle, with ack low and interrupts on
  assign launch = (state_q == irq_pkg::ARB_IDLE) && irq_glb_en_i && !irq_ack_i && sel_valid;

  always_comb begin
    state_d = state_q;
    case (state_q)
      irq_pkg::ARB_IDLE: begin
        if (launch) begin
          state_d = irq_pkg::ARB_REQ;
        end
      end
      // Hold until the core acknowledges
      irq_pkg::ARB_REQ: begin
        if (irq_ack_i) begin
          state_d = irq_pkg::ARB_WAIT;
        end
      end
      // Ack must drop before the next request
      irq_pkg::ARB_WAIT: begin
        if (!irq_ack_i) begin
          state_d = irq_pkg::ARB_IDLE;
        end
      end
      default: begin
        state_d = irq_pkg::ARB_IDLE;
      end
    endcase
  end

  // Id captured on the request rise only
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q <= irq_pkg::ARB_IDLE;
      id_q    <= '0;
    end else begin
      state_q <= state_d;
      if (launch) begin
        id_q <= sel_id;
      end
    end
  end

  assign irq_req_o = (state_q == irq_pkg::ARB_REQ);
  assign irq_id_o  = id_q;

  // Id frozen through request and ack-low wait
  a_id_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (state_q != irq_pkg::ARB_IDLE) |=> $stable(irq_id_o));

  // Request only drops after an ack
  a_req_fall: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    $fell(irq_req_o) |-> $past(irq_ack_i));

  // No request rise while ack is still high
  a_req_rise: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    $rose(irq_req_o) |-> !$past(irq_ack_i));

endmodule

// File: irq_ctrl/irq_group_sel.sv
////////////////////////////////////////////////////////////
// Group selector over one slice of enabled pending lines
// Highest-numbered set line wins
////////////////////////////////////////////////////////////

module irq_group_sel (
  // Enabled pending lines of this group
  input  logic [irq_pkg::GROUP_SIZE-1:0]  pend_i,

  // Any line set in the group
  output logic                            grp_valid_o,

  // Group-local index of the winner
  output logic [irq_pkg::GROUP_IDX_W-1:0] grp_idx_o
);

  ////////////////////////////////////////////////////////////
  // Priority encoder
  ////////////////////////////////////////////////////////////

  // Later iterations overwrite, so the top set bit remains
  always_comb begin
    grp_idx_o = '0;
    for (int i = 0; i < irq_pkg::GROUP_SIZE; i++) begin
      if (pend_i[i]) begin
        grp_idx_o = i[irq_pkg::GROUP_IDX_W-1:0];
      end
    end
  end

  // Index is only meaningful with valid
  assign grp_valid_o = |pend_i;

endmodule

// File: irq_ctrl/irq_sampler.sv
////////////////////////////////////////////////////////////
// Interrupt line sampling into mip
// mie register with implemented-bit mask
// Enabled pending word and wake-up flag
////////////////////////////////////////////////////////////

module irq_sampler (
  // Clock and reset
  input  logic                        clk_i,
  input  logic                        rst_n_i,

  // Level-sensitive interrupt lines
  input  logic [irq_pkg::IRQ_NUM-1:0] irq_i,

  // mie write port from the CSR side
  input  logic                        mie_we_i,
  input  logic [irq_pkg::IRQ_NUM-1:0] mie_wdata_i,

  // Register views
  output logic [irq_pkg::IRQ_NUM-1:0] mip_o,
  output logic [irq_pkg::IRQ_NUM-1:0] mie_o,

  // Enabled pending lines, towards selectors and arbiter
  output irq_pkg::irq_word_u          irq_pend_en_o,

  // Wake-up for the sleep logic
  output logic                        irq_wu_o
);

  logic [irq_pkg::IRQ_NUM-1:0] mip_q;
  logic [irq_pkg::IRQ_NUM-1:0] mie_q;

  // Sample the lines every cycle
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      mip_q <= '0;
    end else begin
      mip_q <= irq_i;
    end
  end

  // Unimplemented enable bits stay zero
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      mie_q <= '0;
    end else if (mie_we_i) begin
      mie_q <= mie_wdata_i & irq_pkg::MIE_MASK;
    end
  end

  assign mip_o = mip_q;
  assign mie_o = mie_q;

  // Pending and enabled
  assign irq_pend_en_o.flat = mip_q & mie_q;

  // Wake up on any enabled pending line, global enable ignored
  assign irq_wu_o = |irq_pend_en_o.flat;

  // mie never reaches beyond the implemented bits
  a_mie_masked: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (mie_o & ~irq_pkg::MIE_MASK) == '0);

endmodule

// File: common/irq_pkg.sv
////////////////////////////////////////////////////////////
// Interrupt controller shared definitions
// Line counts, group geometry, standard ids and enable mask
// Arbiter state encodings, id type, interrupt word union
////////////////////////////////////////////////////////////

package irq_pkg;

  // Number of interrupt lines
  localparam int unsigned IRQ_NUM = 32;

  // Width of an interrupt id
  localparam int unsigned IRQ_ID_W = 5;

  // Lines handled by one group selector
  localparam int unsigned GROUP_SIZE = 8;
  localparam int unsigned GROUP_NUM = IRQ_NUM / GROUP_SIZE;

  // Group-local index width and group number width inside an id
  localparam int unsigned GROUP_IDX_W = $clog2(GROUP_SIZE);
  localparam int unsigned GROUP_NUM_W = IRQ_ID_W - GROUP_IDX_W;

  // Implemented mie bits are custom 31 to 16 plus 11, 7 and 3
  localparam logic [IRQ_NUM-1:0] MIE_MASK = 32'hFFFF_0888;

  // Interrupt id
  typedef logic [IRQ_ID_W-1:0] irq_id_t;

  // Standard machine interrupt ids
  localparam irq_id_t IRQ_MSI = 5'd3;
  localparam irq_id_t IRQ_MTI = 5'd7;
  localparam irq_id_t IRQ_MEI = 5'd11;

  // Arbiter handshake states
  localparam logic [1:0] ARB_IDLE = 2'd0;
  localparam logic [1:0] ARB_REQ  = 2'd1;
  localparam logic [1:0] ARB_WAIT = 2'd2;

  // One interrupt word, flat or split into the mip/mie fields
  typedef union packed {
    logic [IRQ_NUM-1:0] flat;
    struct packed {
      logic [15:0] custom;
      logic [3:0]  rsvd_15_12;
      logic        meie;
      logic [2:0]  rsvd_10_8;
      logic        mtie;
      logic [2:0]  rsvd_6_4;
      logic        msie;
      logic [2:0]  rsvd_2_0;
    } fields;
  } irq_word_u;

endpackage
